// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and storage sizes
`define wordWidth 16    // Data word width
`define regCount 16     // Registers, 4-bit numbers
`define memDepth 256    // Memory words, 8-bit addresses

// Flow control
`define reqCredits 2    // Depth of each arbiter request queue
`define instrCredits 4  // Depth of the core instruction queue

`define resetPc 0       // First fetch address

`endif

// File: cpuPkg.sv
`include "cpu_config.svh"

package cpuPkg;

  // Opcode field, top nibble of the instruction
  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    ADDI = 4'h5,  // rd = rs + simm4(rt)
    LLI  = 4'h6,  // rd = {8'h00, rs, rt}
    LHI  = 4'h7,  // rd = {rs, rt, rd[7:0]}
    LW   = 4'h8,  // rd = mem[rs + simm4(rt)]
    SW   = 4'h9,  // mem[rs + simm4(rt)] = rd
    HALT = 4'ha
  } opcodeT;

  typedef struct packed {
    opcodeT     opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;  // Also imm4 or low half of imm8
  } instrT;

  // Requester id, steers the read response back
  typedef enum logic {FETCH = 1'b0, DATA = 1'b1} srcT;

  typedef struct packed {
    srcT                           src;
    logic                          write;
    logic [$clog2(`memDepth)-1:0]  addr;
    logic [`wordWidth-1:0]         data;  // Store data, unused on reads
  } memReqT;

  typedef struct packed {
    logic                  valid;
    srcT                   src;
    logic [`wordWidth-1:0] data;
  } memRspT;

  typedef struct packed {
    logic                          valid;
    logic [$clog2(`regCount)-1:0]  regNum;  // Destination register
    logic [`wordWidth-1:0]         data;
  } retireT;

endpackage

// File: creditFifo.sv
module creditFifo #(
  parameter type payloadT = logic [15:0],
  parameter int  depth    = 2
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    push,
  input  payloadT pushData,
  input  logic    pop,
  output payloadT popData,
  output logic    notEmpty,
  output logic    creditReturn
);

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW = $clog2(depth + 1);

  payloadT         entries [depth];  // Circular storage
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;            // Occupied entries
  logic            doPop;

  assign notEmpty     = (count != '0);
  assign doPop        = pop && notEmpty;  // Pop on empty is ignored
  assign popData      = entries[rdPtr];   // Head, valid while notEmpty
  assign creditReturn = doPop;            // One credit back per entry freed

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) entries[wrPtr] <= pushData;
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop) rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      count <= count + cntW'(push) - cntW'(doPop);
    end
  end

  // A sender within its credits never finds the queue full
  assert property (@(posedge clk) disable iff (rst) push |-> (count != cntW'(depth)))
    else $error("creditFifo push while full, sender exceeded its credits");

endmodule

// File: regFile.sv
`include "cpu_config.svh"

module regFile (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [$clog2(`regCount)-1:0] srcReg1,
  input  logic [$clog2(`regCount)-1:0] srcReg2,
  input  logic [$clog2(`regCount)-1:0] dstReg,
  input  logic                         writeReg,
  input  logic [`wordWidth-1:0]        dstData,
  output logic [`wordWidth-1:0]        srcData1,
  output logic [`wordWidth-1:0]        srcData2
);

  localparam int addrW = $clog2(`regCount);

  logic [`wordWidth-1:0] regs [`regCount];
  logic [`wordWidth-1:0] writeVal;        // Zero when targeting register 0
  logic [`wordWidth-1:0] read1Q, read2Q;  // Sampled read data
  logic [addrW-1:0]      addr1Q, addr2Q;  // Sampled read addresses

  assign writeVal = (dstReg == '0) ? '0 : dstData;

  always_ff @(posedge clk) begin
    if (rst) begin
      regs   <= '{default: '0};  // All registers start at zero
      read1Q <= '0;
      read2Q <= '0;
      addr1Q <= '0;
      addr2Q <= '0;
    end else begin
      addr1Q <= srcReg1;
      addr2Q <= srcReg2;
      // Write-first when the sampling edge also writes the register
      read1Q <= (writeReg && dstReg == srcReg1) ? writeVal : regs[srcReg1];
      read2Q <= (writeReg && dstReg == srcReg2) ? writeVal : regs[srcReg2];
      if (writeReg) regs[dstReg] <= writeVal;
    end
  end

  // Read data one cycle after the address
  assign srcData1 = read1Q;
  assign srcData2 = read2Q;

  ////////////////////////////////////////////////////////////
  // Register 0 reads as zero through both ports
  ////////////////////////////////////////////////////////////
  assert property (@(posedge clk) disable iff (rst) (addr1Q == '0) |-> (srcData1 == '0))
    else $error("regFile port 1 read nonzero from register 0");
  assert property (@(posedge clk) disable iff (rst) (addr2Q == '0) |-> (srcData2 == '0))
    else $error("regFile port 2 read nonzero from register 0");

endmodule

// File: sharedMem.sv
`include "cpu_config.svh"

module sharedMem (
  input  logic                         clk,
  input  cpuPkg::memReqT               req,
  input  logic                         reqValid,
  output cpuPkg::memRspT               rsp,
  input  logic                         loadEn,
  input  logic [$clog2(`memDepth)-1:0] loadAddr,
  input  logic [`wordWidth-1:0]        loadData
);

  logic [`wordWidth-1:0] mem [`memDepth];  // Contents survive reset

  // Single write port, host load has priority
  always_ff @(posedge clk) begin
    if (loadEn) begin
      mem[loadAddr] <= loadData;
    end else if (reqValid && req.write) begin
      mem[req.addr] <= req.data;
    end
  end

  // Read answers one cycle after the grant
  always_ff @(posedge clk) begin
    rsp.valid <= reqValid && !req.write;  // Clears when no read granted
    rsp.src   <= req.src;                 // Echo requester for steering
    rsp.data  <= mem[req.addr];
  end

endmodule

// File: memArbiter.sv
`include "cpu_config.svh"

module memArbiter (
  input  logic           clk,
  input  logic           rst,
  input  cpuPkg::memReqT fetchReq,
  input  cpuPkg::memReqT dataReq,
  input  logic           fetchPush,
  input  logic           dataPush,
  output logic           fetchCredit,
  output logic           dataCredit,
  output cpuPkg::memReqT memReq,
  output logic           memReqValid,
  input  cpuPkg::memRspT memRsp,
  output cpuPkg::memRspT fetchRsp,
  output cpuPkg::memRspT dataRsp
);

  cpuPkg::memReqT fetchHead, dataHead;
  logic           fetchNotEmpty, dataNotEmpty;
  logic           popFetch, popData;
  cpuPkg::srcT    lastGrant;  // Requester served most recently

  ////////////////////////////////////////////////////////////
  // Request queues, one per requester
  ////////////////////////////////////////////////////////////
  creditFifo #(.payloadT(cpuPkg::memReqT), .depth(`reqCredits)) fetchQueue (
    .clk(clk), .rst(rst),
    .push(fetchPush), .pushData(fetchReq),
    .pop(popFetch), .popData(fetchHead),
    .notEmpty(fetchNotEmpty), .creditReturn(fetchCredit)
  );

  creditFifo #(.payloadT(cpuPkg::memReqT), .depth(`reqCredits)) dataQueue (
    .clk(clk), .rst(rst),
    .push(dataPush), .pushData(dataReq),
    .pop(popData), .popData(dataHead),
    .notEmpty(dataNotEmpty), .creditReturn(dataCredit)
  );

  ////////////////////////////////////////////////////////////
  // Round-robin grant
  ////////////////////////////////////////////////////////////
  assign popFetch = fetchNotEmpty && (!dataNotEmpty || lastGrant == cpuPkg::DATA);
  assign popData  = dataNotEmpty && !popFetch;  // Alone, or its turn

  assign memReq      = popFetch ? fetchHead : dataHead;
  assign memReqValid = popFetch || popData;

  always_ff @(posedge clk) begin
    if (rst) begin
      lastGrant <= cpuPkg::DATA;  // Fetch wins the first tie
    end else if (memReqValid) begin
      lastGrant <= popFetch ? cpuPkg::FETCH : cpuPkg::DATA;
    end
  end

  // Response steering by source id
  always_comb begin
    fetchRsp       = memRsp;
    dataRsp        = memRsp;
    fetchRsp.valid = memRsp.valid && (memRsp.src == cpuPkg::FETCH);
    dataRsp.valid  = memRsp.valid && (memRsp.src == cpuPkg::DATA);
  end

  // One memory port, so one queue head per cycle
  assert property (@(posedge clk) disable iff (rst) !(fetchCredit && dataCredit))
    else $error("memArbiter popped both request queues in one cycle");

endmodule

// File: fetchUnit.sv
`include "cpu_config.svh"

module fetchUnit (
  input  logic           clk,
  input  logic           rst,
  input  logic           halted,
  output cpuPkg::memReqT memReq,
  output logic           memPush,
  input  logic           memCredit,
  input  cpuPkg::memRspT memRsp,
  output logic           instrPush,
  output cpuPkg::instrT  instrData,
  input  logic           instrCredit
);

  localparam int addrW     = $clog2(`memDepth);
  localparam int reqCntW   = $clog2(`reqCredits + 1);
  localparam int instrCntW = $clog2(`instrCredits + 1);

  logic [addrW-1:0]     pc;        // Next fetch address
  logic [reqCntW-1:0]   reqCnt;    // Free arbiter queue slots
  logic [instrCntW-1:0] instrCnt;  // Free instruction queue slots
  logic                 issue;

  // Both credits held, so the queue and the response have room
  assign issue   = !halted && (reqCnt != '0) && (instrCnt != '0);
  assign memPush = issue;

  always_comb begin
    memReq      = '0;             // Read, no store data
    memReq.src  = cpuPkg::FETCH;
    memReq.addr = pc;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= addrW'(`resetPc);
      reqCnt   <= reqCntW'(`reqCredits);
      instrCnt <= instrCntW'(`instrCredits);
    end else begin
      if (issue) pc <= pc + 1'b1;  // Straight-line program
      reqCnt   <= reqCnt - reqCntW'(issue) + reqCntW'(memCredit);
      instrCnt <= instrCnt - instrCntW'(issue) + instrCntW'(instrCredit);
    end
  end

  // Returned words go straight to the core queue
  assign instrPush = memRsp.valid;
  assign instrData = cpuPkg::instrT'(memRsp.data);

endmodule

// File: execCore.sv
`include "cpu_config.svh"

module execCore (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         instrPush,
  input  cpuPkg::instrT                instrData,
  output logic                         instrCredit,
  output cpuPkg::memReqT               memReq,
  output logic                         memPush,
  input  logic                         memCredit,
  input  cpuPkg::memRspT               memRsp,
  output logic [$clog2(`regCount)-1:0] srcReg1,
  output logic [$clog2(`regCount)-1:0] srcReg2,
  output logic [$clog2(`regCount)-1:0] dstReg,
  output logic                         writeReg,
  output logic [`wordWidth-1:0]        dstData,
  input  logic [`wordWidth-1:0]        srcData1,
  input  logic [`wordWidth-1:0]        srcData2,
  output cpuPkg::retireT               retire,
  output logic                         halted
);

  localparam int memCntW = $clog2(`reqCredits + 1);

  typedef enum logic [2:0] {sIdle, sRead, sExec, sMemWait, sHalt} stateT;

  stateT                 state, nextState;
  cpuPkg::instrT         headInstr;       // Queue head
  cpuPkg::instrT         instrQ;          // Instruction in progress
  logic                  queueNotEmpty;
  logic                  popInstr;
  logic [memCntW-1:0]    memCnt;          // Data request credits
  logic                  isMem, isWrite;
  logic [`wordWidth-1:0] immSext;         // Sign-extended imm4
  logic [7:0]            imm8;            // {rs, rt}
  logic [`wordWidth-1:0] aluOut;

  ////////////////////////////////////////////////////////////
  // Instruction queue, credits go back to fetch
  ////////////////////////////////////////////////////////////
  creditFifo #(.payloadT(cpuPkg::instrT), .depth(`instrCredits)) instrQueue (
    .clk(clk), .rst(rst),
    .push(instrPush), .pushData(instrData),
    .pop(popInstr), .popData(headInstr),
    .notEmpty(queueNotEmpty), .creditReturn(instrCredit)
  );

  assign popInstr = (state == sIdle) && queueNotEmpty;

  always_ff @(posedge clk) begin
    if (popInstr) instrQ <= headInstr;
  end

  ////////////////////////////////////////////////////////////
  // Control sequence
  ////////////////////////////////////////////////////////////
  assign isMem   = (instrQ.opcode == cpuPkg::LW) || (instrQ.opcode == cpuPkg::SW);
  assign isWrite = (instrQ.opcode <= cpuPkg::LHI);  // ALU and immediates

  always_comb begin
    nextState = state;
    case (state)
      sIdle:    if (popInstr) nextState = sRead;
      sRead:    nextState = sExec;  // Register file samples here
      sExec: begin
        if (instrQ.opcode == cpuPkg::HALT) nextState = sHalt;
        else if (!isMem) nextState = sIdle;
        else if (memCnt != '0) nextState = (instrQ.opcode == cpuPkg::LW) ? sMemWait : sIdle;
      end
      sMemWait: if (memRsp.valid) nextState = sIdle;
      default:  nextState = sHalt;  // Stays until reset
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) state <= sIdle;
    else state <= nextState;
  end

  assign halted = (state == sHalt);

  ////////////////////////////////////////////////////////////
  // Operands and ALU
  ////////////////////////////////////////////////////////////
  assign srcReg1 = instrQ.rs;  // Base for LW and SW
  assign srcReg2 = (instrQ.opcode == cpuPkg::LHI || instrQ.opcode == cpuPkg::SW) ?
                   instrQ.rd : instrQ.rt;  // Old rd for LHI, store data for SW
  assign immSext = {{(`wordWidth-4){instrQ.rt[3]}}, instrQ.rt};
  assign imm8    = {instrQ.rs, instrQ.rt};

  always_comb begin
    case (instrQ.opcode)
      cpuPkg::ADD:  aluOut = srcData1 + srcData2;
      cpuPkg::SUB:  aluOut = srcData1 - srcData2;
      cpuPkg::AND:  aluOut = srcData1 & srcData2;
      cpuPkg::OR:   aluOut = srcData1 | srcData2;
      cpuPkg::XOR:  aluOut = srcData1 ^ srcData2;
      cpuPkg::ADDI: aluOut = srcData1 + immSext;
      cpuPkg::LLI:  aluOut = {8'h00, imm8};             // Zero-extended byte
      cpuPkg::LHI:  aluOut = {imm8, srcData2[7:0]};     // Keep low byte
      default:      aluOut = '0;
    endcase
  end

  // Register write, from the ALU or the load response
  assign writeReg = ((state == sExec) && isWrite) || ((state == sMemWait) && memRsp.valid);
  assign dstReg   = instrQ.rd;
  assign dstData  = (instrQ.rd == '0) ? '0 :
                    (state == sMemWait) ? memRsp.data : aluOut;

  always_comb begin
    retire.valid  = writeReg;  // Every register write is reported
    retire.regNum = dstReg;
    retire.data   = dstData;
  end

  ////////////////////////////////////////////////////////////
  // Load/store requests
  ////////////////////////////////////////////////////////////
  assign memPush = (state == sExec) && isMem && (memCnt != '0);  // Held without credit

  always_comb begin
    memReq       = '0;
    memReq.src   = cpuPkg::DATA;
    memReq.write = (instrQ.opcode == cpuPkg::SW);
    memReq.addr  = srcData1[7:0] + immSext[7:0];
    memReq.data  = srcData2;  // rd for SW
  end

  always_ff @(posedge clk) begin
    if (rst) memCnt <= memCntW'(`reqCredits);
    else memCnt <= memCnt - memCntW'(memPush) + memCntW'(memCredit);
  end

  // Data responses only ever answer an outstanding LW
  assert property (@(posedge clk) disable iff (rst) memRsp.valid |-> (state == sMemWait))
    else $error("execCore memory response with no load pending");

endmodule

// File: cpuTop.sv
module cpuTop (
  input  logic           clk,
  input  logic           rst,
  input  logic           loadEn,
  input  logic [7:0]     loadAddr,
  input  logic [15:0]    loadData,
  output cpuPkg::retireT retire,
  output logic           halted
);

  cpuPkg::memReqT fetchReq, dataReq, memReq;
  cpuPkg::memRspT memRsp, fetchRsp, dataRsp;
  cpuPkg::instrT  instrData;
  logic           fetchPush, dataPush, fetchCredit, dataCredit, memReqValid;
  logic           instrPush, instrCredit, writeReg;
  logic [3:0]     srcReg1, srcReg2, dstReg;
  logic [15:0]    dstData, srcData1, srcData2;

  execCore core (
    .clk(clk), .rst(rst),
    .instrPush(instrPush), .instrData(instrData), .instrCredit(instrCredit),
    .memReq(dataReq), .memPush(dataPush), .memCredit(dataCredit), .memRsp(dataRsp),
    .srcReg1(srcReg1), .srcReg2(srcReg2), .dstReg(dstReg),
    .writeReg(writeReg), .dstData(dstData),
    .srcData1(srcData1), .srcData2(srcData2),
    .retire(retire), .halted(halted)
  );

  fetchUnit fetch (
    .clk(clk), .rst(rst), .halted(halted),
    .memReq(fetchReq), .memPush(fetchPush), .memCredit(fetchCredit), .memRsp(fetchRsp),
    .instrPush(instrPush), .instrData(instrData), .instrCredit(instrCredit)
  );

  memArbiter arb (
    .clk(clk), .rst(rst),
    .fetchReq(fetchReq), .dataReq(dataReq),
    .fetchPush(fetchPush), .dataPush(dataPush),
    .fetchCredit(fetchCredit), .dataCredit(dataCredit),
    .memReq(memReq), .memReqValid(memReqValid),
    .memRsp(memRsp), .fetchRsp(fetchRsp), .dataRsp(dataRsp)
  );

  // Host loads only land while reset holds the core
  sharedMem mem (
    .clk(clk), .req(memReq), .reqValid(memReqValid), .rsp(memRsp),
    .loadEn(loadEn && rst), .loadAddr(loadAddr), .loadData(loadData)
  );

  regFile regs (
    .clk(clk), .rst(rst),
    .srcReg1(srcReg1), .srcReg2(srcReg2), .dstReg(dstReg),
    .writeReg(writeReg), .dstData(dstData),
    .srcData1(srcData1), .srcData2(srcData2)
  );

endmodule

// File: tbCpu.sv
module tbCpu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int numTests = 5;
  localparam int maxWords = 16;
  localparam int haltTimeout = 2000;  // Cycles allowed for one program

  logic           clk;
  logic           rst;
  logic           loadEn;
  logic [7:0]     loadAddr;
  logic [15:0]    loadData;
  cpuPkg::retireT retire;
  logic           halted;

  cpuTop DUT (
    .clk(clk), .rst(rst),
    .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
    .retire(retire), .halted(halted)
  );

  // Program table
  string       testName [numTests];
  logic [15:0] prog [numTests][maxWords];
  int          progLen [numTests];

  logic [15:0]    modelReg [16];
  logic [15:0]    modelMem [256];  // Data words, kept across tests like the RAM
  cpuPkg::retireT expQ[$];
  cpuPkg::retireT gotQ[$];
  logic [31:0]    lfsr;
  string          curName;
  int             errors;
  int             checks;
  logic           rstSeen;         // Reset already held at the previous sample

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [15:0] mk(cpuPkg::opcodeT op, int rd, int rs, int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  function automatic logic lfsrBit();  // Galois LFSR, one step per bit
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) lfsr = lfsr ^ 32'h8020_0003;
    return lsb;
  endfunction

  function automatic logic [7:0] randByte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) b[i] = lfsrBit();
    return b;
  endfunction

  function automatic logic [15:0] loadByte(cpuPkg::opcodeT op, int rd, logic [7:0] b);
    return {op, 4'(rd), b};  // LLI or LHI with imm8 in rs and rt
  endfunction

  task automatic addWord(int t, logic [15:0] w);
    prog[t][progLen[t]] = w;
    progLen[t]++;
  endtask

  task automatic buildTable();
    for (int t = 0; t < numTests; t++) progLen[t] = 0;
    testName[0] = "aluOps";
    addWord(0, loadByte(cpuPkg::LLI, 1, randByte()));
    addWord(0, loadByte(cpuPkg::LHI, 1, randByte()));
    addWord(0, loadByte(cpuPkg::LLI, 2, randByte()));
    addWord(0, loadByte(cpuPkg::LHI, 2, randByte()));
    addWord(0, mk(cpuPkg::ADD, 3, 1, 2));
    addWord(0, mk(cpuPkg::SUB, 4, 1, 2));
    addWord(0, mk(cpuPkg::AND, 5, 1, 2));
    addWord(0, mk(cpuPkg::OR, 6, 1, 2));
    addWord(0, mk(cpuPkg::XOR, 7, 1, 2));
    addWord(0, mk(cpuPkg::ADDI, 8, 1, 4'hd));  // Minus 3
    addWord(0, mk(cpuPkg::ADDI, 9, 2, 7));
    addWord(0, mk(cpuPkg::HALT, 0, 0, 0));
    testName[1] = "regZero";
    addWord(1, loadByte(cpuPkg::LLI, 0, randByte()));
    addWord(1, loadByte(cpuPkg::LLI, 1, randByte()));
    addWord(1, mk(cpuPkg::ADD, 0, 1, 1));
    addWord(1, mk(cpuPkg::ADDI, 0, 1, 5));
    addWord(1, mk(cpuPkg::ADD, 2, 0, 0));
    addWord(1, mk(cpuPkg::ADDI, 3, 0, 1));
    addWord(1, mk(cpuPkg::OR, 4, 0, 1));
    addWord(1, mk(cpuPkg::HALT, 0, 0, 0));
    testName[2] = "bypass";
    addWord(2, loadByte(cpuPkg::LLI, 1, randByte()));
    addWord(2, mk(cpuPkg::ADDI, 1, 1, 1));
    addWord(2, mk(cpuPkg::ADD, 2, 1, 1));
    addWord(2, mk(cpuPkg::SUB, 3, 2, 1));
    addWord(2, mk(cpuPkg::XOR, 3, 3, 2));
    addWord(2, mk(cpuPkg::ADD, 4, 3, 3));
    addWord(2, mk(cpuPkg::ADDI, 4, 4, 4'hf));
    addWord(2, loadByte(cpuPkg::LHI, 4, randByte()));
    addWord(2, mk(cpuPkg::HALT, 0, 0, 0));
    testName[3] = "loadStore";  // Data lives at 0x7e and up, far from code
    addWord(3, loadByte(cpuPkg::LLI, 1, 8'h80));
    addWord(3, loadByte(cpuPkg::LLI, 2, randByte()));
    addWord(3, loadByte(cpuPkg::LHI, 2, randByte()));
    addWord(3, loadByte(cpuPkg::LLI, 3, randByte()));
    addWord(3, mk(cpuPkg::SW, 2, 1, 0));
    addWord(3, mk(cpuPkg::SW, 3, 1, 1));
    addWord(3, mk(cpuPkg::SW, 2, 1, 4'he));    // Minus 2
    addWord(3, mk(cpuPkg::LW, 4, 1, 0));
    addWord(3, mk(cpuPkg::LW, 5, 1, 1));
    addWord(3, mk(cpuPkg::LW, 6, 1, 4'he));
    addWord(3, mk(cpuPkg::ADDI, 7, 1, 3));
    addWord(3, mk(cpuPkg::SW, 5, 7, 0));
    addWord(3, mk(cpuPkg::LW, 8, 7, 0));
    addWord(3, mk(cpuPkg::HALT, 0, 0, 0));
    testName[4] = "afterReset";  // Registers from earlier runs must be gone
    addWord(4, mk(cpuPkg::ADD, 1, 2, 3));
    addWord(4, mk(cpuPkg::OR, 4, 1, 9));
    addWord(4, mk(cpuPkg::ADDI, 6, 8, 0));
    addWord(4, loadByte(cpuPkg::LLI, 7, randByte()));
    addWord(4, mk(cpuPkg::HALT, 0, 0, 0));
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model from the instruction rules
  ////////////////////////////////////////////////////////////
  task automatic modelRun(int t);
    logic [15:0] w, v, sx;
    logic [3:0]  rd, rs, rt;
    logic [7:0]  a;
    logic        wr;
    expQ.delete();
    for (int r = 0; r < 16; r++) modelReg[r] = '0;
    for (int i = 0; i < progLen[t]; i++) begin
      w  = prog[t][i];
      rd = w[11:8];
      rs = w[7:4];
      rt = w[3:0];
      sx = {{12{rt[3]}}, rt};
      a  = modelReg[rs][7:0] + sx[7:0];
      wr = 1'b1;
      v  = '0;
      case (w[15:12])
        cpuPkg::ADD:  v = modelReg[rs] + modelReg[rt];
        cpuPkg::SUB:  v = modelReg[rs] - modelReg[rt];
        cpuPkg::AND:  v = modelReg[rs] & modelReg[rt];
        cpuPkg::OR:   v = modelReg[rs] | modelReg[rt];
        cpuPkg::XOR:  v = modelReg[rs] ^ modelReg[rt];
        cpuPkg::ADDI: v = modelReg[rs] + sx;
        cpuPkg::LLI:  v = {8'h00, rs, rt};
        cpuPkg::LHI:  v = {rs, rt, modelReg[rd][7:0]};
        cpuPkg::LW:   v = modelMem[a];
        cpuPkg::SW: begin
          modelMem[a] = modelReg[rd];
          wr = 1'b0;
        end
        default: break;  // HALT ends the program
      endcase
      if (wr) begin
        if (rd == 4'd0) v = '0;
        modelReg[rd] = v;
        expQ.push_back({1'b1, rd, v});
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Retire monitor and reset checks
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rst) begin
      if (rstSeen) begin
        assert (!retire.valid && !halted) else begin
          errors++;
          $display("retire or halted active during reset in %s", curName);
        end
      end
      rstSeen <= 1'b1;
    end else begin
      if (rstSeen) begin
        assert (!retire.valid && !halted) else begin
          errors++;
          $display("retire or halted high right after reset in %s", curName);
        end
      end
      assert (!(halted && retire.valid)) else begin
        errors++;
        $display("register write retired after halt in %s", curName);
      end
      if (retire.valid) gotQ.push_back(retire);
      rstSeen <= 1'b0;
    end
  end

  task automatic runTest(int t);
    int cycles;
    int waited;
    curName = testName[t];
    cycles  = (progLen[t] + 1 > 10) ? progLen[t] + 1 : 10;
    @(posedge clk);
    #1;
    rst = 1'b1;
    for (int c = 0; c < cycles; c++) begin
      loadEn   = (c < progLen[t]);
      loadAddr = 8'(c);
      loadData = (c < progLen[t]) ? prog[t][c] : '0;
      @(posedge clk);
      #1;
    end
    loadEn = 1'b0;
    gotQ.delete();
    rst    = 1'b0;
    waited = 0;
    while (!halted && waited < haltTimeout) begin
      @(negedge clk);
      waited++;
    end
    assert (halted) else begin
      errors++;
      $display("timeout waiting for halted in %s", curName);
    end
    for (int i = 0; i < 8; i++) @(negedge clk);  // Watch for late retires
    modelRun(t);
    checks++;
    assert (gotQ.size() == expQ.size()) else begin
      errors++;
      $display("Error %s retire count expected %0d actual %0d",
               curName, expQ.size(), gotQ.size());
    end
    for (int i = 0; i < expQ.size() && i < gotQ.size(); i++) begin
      checks++;
      assert (gotQ[i] == expQ[i]) else begin
        errors++;
        $display("Error %s retire %0d expected r%0d=%h actual r%0d=%h", curName, i,
                 expQ[i].regNum, expQ[i].data, gotQ[i].regNum, gotQ[i].data);
      end
    end
  endtask

  initial begin
    rst      = 1'b1;
    loadEn   = 1'b0;
    loadAddr = '0;
    loadData = '0;
    rstSeen  = 1'b0;
    errors   = 0;
    checks   = 0;
    lfsr     = 32'h7c67_ab2f;
    curName  = "init";
    buildTable();
    for (int t = 0; t < numTests; t++) runTest(t);
    $display("tbCpu summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
cpuPkg.sv
creditFifo.sv
regFile.sv
sharedMem.sv
memArbiter.sv
fetchUnit.sv
execCore.sv
cpuTop.sv
tbCpu.sv

// File: runSim.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tbCpu -o VtbCpu

./obj_dir/VtbCpu > sim.log 2>&1 || true
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
exit 1
